// ==== include/cvrp_params.svh ====
// Build-time sizes of the CVRP controller; node count must be at least two, population below 512
`ifndef CVRP_PARAMS_SVH
`define CVRP_PARAMS_SVH

////////////////////////////////////////////////////////////
// Problem and population size
////////////////////////////////////////////////////////////

// Number of node sequencers working in parallel
`define CVRP_NUM_NODES 4

// Number of cities in one route
`define CVRP_NUM_CITIES 16

// The population holds twenty individuals per city
`define CVRP_POP_SIZE (20 * `CVRP_NUM_CITIES)

////////////////////////////////////////////////////////////
// Run schedule and memory traffic
////////////////////////////////////////////////////////////

// Grants made while the population is still being initialized
`define CVRP_INIT_RUNS 8

// Total number of grants, init runs included
`define CVRP_NUM_RUNS 40

// Memory words needed to move one individual in or out
`define CVRP_MEM_ACCESSES 5

// Width of a fitness value, large enough for the longest route
`define CVRP_FIT_W 13

`endif

// ==== list.f ====
+incdir+include
src/cvrp_pkg.sv
src/parent_selector.sv
src/node_sequencer.sv
src/run_controller.sv
src/cvrp_controller.sv
verification/cvrp_controller_props.sv
verification/cvrp_controller_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator was not found"
	exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f list.f --top-module cvrp_controller_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "compilation failed"
	exit 1
fi

output=$(./obj_dir/Vcvrp_controller_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

// ==== src/cvrp_controller.sv ====
// Top level of the CVRP controller; the result strobe has no back-pressure and needs a node in WAIT_RESULT
`include "cvrp_params.svh"

module cvrp_controller (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                result_valid_i,
	input  cvrp_pkg::node_idx_t result_node_i,
	input  cvrp_pkg::fitness_t  result_fitness_i,
	input  logic                result_slot_i,
	input  logic                result_unchanged_i,
	output logic                grant_valid_o,
	output cvrp_pkg::node_idx_t grant_node_o,
	output cvrp_pkg::ind_num_t  grant_parent_1_o,
	output cvrp_pkg::ind_num_t  grant_parent_2_o,
	output logic                grant_init_o,
	output logic                done_o,
	output cvrp_pkg::fitness_t  best_fitness_o,
	output cvrp_pkg::ind_num_t  best_address_o
);
	import cvrp_pkg::*;

	// Grant bus from the selector
	node_mask_t grant;
	ind_num_t   parent_1;
	ind_num_t   parent_2;

	// Per-node status, bit or entry n belongs to node n
	node_mask_t req;
	node_mask_t idle;
	node_mask_t in_use_valid;
	ind_num_t [`CVRP_NUM_NODES-1:0] in_use_1;
	ind_num_t [`CVRP_NUM_NODES-1:0] in_use_2;
	fitness_t [`CVRP_NUM_NODES-1:0] node_best_fitness;
	ind_num_t [`CVRP_NUM_NODES-1:0] node_best_address;

	// Phase flags of the run controller
	logic run_enable;
	logic init_phase;

	parent_selector parent_selector_i (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.run_enable_i   (run_enable),
		.req_i          (req),
		.in_use_valid_i (in_use_valid),
		.in_use_1_i     (in_use_1),
		.in_use_2_i     (in_use_2),
		.grant_o        (grant),
		.parent_1_o     (parent_1),
		.parent_2_o     (parent_2)
	);

	////////////////////////////////////////////////////////////
	// Node array
	////////////////////////////////////////////////////////////

	for (genvar n = 0; n < `CVRP_NUM_NODES; n++) begin : g_node
		// Only the addressed node sees the strobe, the payload is shared
		logic node_result_valid;

		assign node_result_valid = result_valid_i && (result_node_i == node_idx_t'(n));

		node_sequencer node_sequencer_i (
			.clk_i              (clk_i),
			.rst_i              (rst_i),
			.run_enable_i       (run_enable),
			.grant_i            (grant[n]),
			.parent_1_i         (parent_1),
			.parent_2_i         (parent_2),
			.result_valid_i     (node_result_valid),
			.result_fitness_i   (result_fitness_i),
			.result_slot_i      (result_slot_i),
			.result_unchanged_i (result_unchanged_i),
			.req_o              (req[n]),
			.idle_o             (idle[n]),
			.in_use_valid_o     (in_use_valid[n]),
			.in_use_1_o         (in_use_1[n]),
			.in_use_2_o         (in_use_2[n]),
			.best_fitness_o     (node_best_fitness[n]),
			.best_address_o     (node_best_address[n])
		);
	end

	run_controller run_controller_i (
		.clk_i               (clk_i),
		.rst_i               (rst_i),
		.grant_valid_i       (grant_valid_o),
		.idle_i              (idle),
		.node_best_fitness_i (node_best_fitness),
		.node_best_address_i (node_best_address),
		.run_enable_o        (run_enable),
		.init_phase_o        (init_phase),
		.done_o              (done_o),
		.best_fitness_o      (best_fitness_o),
		.best_address_o      (best_address_o)
	);

	////////////////////////////////////////////////////////////
	// Grant outputs
	////////////////////////////////////////////////////////////

	// The grant is one-hot, so the encoder only has to find the set bit
	always_comb begin
		grant_node_o = '0;
		for (int n = 0; n < `CVRP_NUM_NODES; n++) begin
			if (grant[n]) begin
				grant_node_o = node_idx_t'(n);
			end
		end
	end

	assign grant_valid_o    = |grant;
	assign grant_parent_1_o = parent_1;
	assign grant_parent_2_o = parent_2;
	assign grant_init_o     = grant_valid_o && init_phase;

endmodule

// ==== src/cvrp_pkg.sv ====
// Shared types of the CVRP controller; widths derive from cvrp_params.svh, node count at least two
`include "cvrp_params.svh"

package cvrp_pkg;

	////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////

	// Index of one individual inside the population
	typedef logic [$clog2(`CVRP_POP_SIZE)-1:0] ind_num_t;

	// Fitness of a route, a smaller value is a better route
	typedef logic [`CVRP_FIT_W-1:0] fitness_t;

	// Index of one node sequencer
	typedef logic [$clog2(`CVRP_NUM_NODES)-1:0] node_idx_t;

	// One bit per node sequencer, bit n belongs to node n
	typedef logic [`CVRP_NUM_NODES-1:0] node_mask_t;

	// Counts grants up to and including the last run
	typedef logic [$clog2(`CVRP_NUM_RUNS + 1)-1:0] run_cnt_t;

	// Counts memory words of one individual
	typedef logic [$clog2(`CVRP_MEM_ACCESSES + 1)-1:0] mem_cnt_t;

	// All-ones marks a best value that has no solution behind it yet
	localparam fitness_t FIT_NONE = '1;
	localparam ind_num_t IND_NONE = '1;

	////////////////////////////////////////////////////////////
	// State machines
	////////////////////////////////////////////////////////////

	// Phases of the whole run
	typedef enum logic [2:0] {
		MS_IDLE          = 3'd0,
		MS_INIT_RUNS     = 3'd1,
		MS_STANDARD_RUNS = 3'd2,
		MS_WAIT_FOR_END  = 3'd3,
		MS_EVALUATE      = 3'd4,
		MS_FINISHED      = 3'd5
	} main_state_t;

	// Steps of one node from grant to write-back
	typedef enum logic [2:0] {
		NS_IDLE           = 3'd0,
		NS_LOAD_PARENT_1  = 3'd1,
		NS_LOAD_PARENT_2  = 3'd2,
		NS_WAIT_RESULT    = 3'd3,
		NS_WB_OFFSPRING_1 = 3'd4,
		NS_WB_OFFSPRING_2 = 3'd5,
		NS_FINAL          = 3'd6
	} node_state_t;

endpackage

// ==== src/node_sequencer.sv ====
// One processing node; results are sampled only in WAIT_RESULT and lost in any other state
`include "cvrp_params.svh"

module node_sequencer (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               run_enable_i,
	input  logic               grant_i,
	input  cvrp_pkg::ind_num_t parent_1_i,
	input  cvrp_pkg::ind_num_t parent_2_i,
	input  logic               result_valid_i,
	input  cvrp_pkg::fitness_t result_fitness_i,
	input  logic               result_slot_i,
	input  logic               result_unchanged_i,
	output logic               req_o,
	output logic               idle_o,
	output logic               in_use_valid_o,
	output cvrp_pkg::ind_num_t in_use_1_o,
	output cvrp_pkg::ind_num_t in_use_2_o,
	output cvrp_pkg::fitness_t best_fitness_o,
	output cvrp_pkg::ind_num_t best_address_o
);
	import cvrp_pkg::*;

	// Value of the access counter on the last word of an individual
	localparam mem_cnt_t LAST_ACCESS = mem_cnt_t'(`CVRP_MEM_ACCESSES);

	node_state_t state_q;
	mem_cnt_t    mem_cnt_q;

	// Pair handed over with the grant
	ind_num_t parent_1_q;
	ind_num_t parent_2_q;

	// Best result this node has seen so far
	fitness_t best_fit_q;
	ind_num_t best_addr_q;

	// Asserted in the one cycle in which a result is accepted
	logic take_result;

	assign take_result = (state_q == NS_WAIT_RESULT) && result_valid_i;

	////////////////////////////////////////////////////////////
	// Node FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q   <= NS_IDLE;
			mem_cnt_q <= '0;
		end else begin
			case (state_q)
				NS_IDLE: begin
					// The grant cycle already issues the first read of parent 1
					if (grant_i) begin
						state_q   <= NS_LOAD_PARENT_1;
						mem_cnt_q <= mem_cnt_t'(1);
					end
				end
				NS_LOAD_PARENT_1: begin
					if (mem_cnt_q == LAST_ACCESS) begin
						// Count 0 in the next state is the idle cycle between the parents
						state_q   <= NS_LOAD_PARENT_2;
						mem_cnt_q <= '0;
					end else begin
						mem_cnt_q <= mem_cnt_q + mem_cnt_t'(1);
					end
				end
				NS_LOAD_PARENT_2: begin
					if (mem_cnt_q == LAST_ACCESS) begin
						state_q <= NS_WAIT_RESULT;
					end else begin
						mem_cnt_q <= mem_cnt_q + mem_cnt_t'(1);
					end
				end
				NS_WAIT_RESULT: begin
					// Unchanged offspring need no write-back at all
					if (result_valid_i) begin
						if (result_unchanged_i) begin
							state_q <= NS_FINAL;
						end else begin
							state_q   <= NS_WB_OFFSPRING_1;
							mem_cnt_q <= mem_cnt_t'(1);
						end
					end
				end
				NS_WB_OFFSPRING_1: begin
					if (mem_cnt_q == LAST_ACCESS) begin
						state_q   <= NS_WB_OFFSPRING_2;
						mem_cnt_q <= mem_cnt_t'(1);
					end else begin
						mem_cnt_q <= mem_cnt_q + mem_cnt_t'(1);
					end
				end
				NS_WB_OFFSPRING_2: begin
					if (mem_cnt_q == LAST_ACCESS) begin
						state_q <= NS_FINAL;
					end else begin
						mem_cnt_q <= mem_cnt_q + mem_cnt_t'(1);
					end
				end
				NS_FINAL: begin
					state_q <= NS_IDLE;
				end
				default: begin
					state_q <= NS_IDLE;
				end
			endcase
		end
	end

	// Pair is captured together with the grant and held until the node is idle again
	always_ff @(posedge clk_i) begin
		if (state_q == NS_IDLE && grant_i) begin
			parent_1_q <= parent_1_i;
			parent_2_q <= parent_2_i;
		end
	end

	////////////////////////////////////////////////////////////
	// Best solution of this node
	////////////////////////////////////////////////////////////

	// Strictly less keeps the earlier of two equal results
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			best_fit_q  <= FIT_NONE;
			best_addr_q <= IND_NONE;
		end else if (take_result && result_fitness_i < best_fit_q) begin
			best_fit_q  <= result_fitness_i;
			// Slot 1 means the better offspring went to the address of parent 2
			best_addr_q <= result_slot_i ? parent_2_q : parent_1_q;
		end
	end

	assign idle_o         = (state_q == NS_IDLE);
	assign req_o          = idle_o && run_enable_i;
	assign in_use_valid_o = !idle_o;
	assign in_use_1_o     = parent_1_q;
	assign in_use_2_o     = parent_2_q;
	assign best_fitness_o = best_fit_q;
	assign best_address_o = best_addr_q;

endmodule

// ==== src/parent_selector.sv ====
// Parent pair proposer and grant arbiter; LFSR taps are fixed for 9-bit individual indices
`include "cvrp_params.svh"

module parent_selector (
	input  logic                                     clk_i,
	input  logic                                     rst_i,
	input  logic                                     run_enable_i,
	input  cvrp_pkg::node_mask_t                     req_i,
	input  cvrp_pkg::node_mask_t                     in_use_valid_i,
	input  cvrp_pkg::ind_num_t [`CVRP_NUM_NODES-1:0] in_use_1_i,
	input  cvrp_pkg::ind_num_t [`CVRP_NUM_NODES-1:0] in_use_2_i,
	output cvrp_pkg::node_mask_t                     grant_o,
	output cvrp_pkg::ind_num_t                       parent_1_o,
	output cvrp_pkg::ind_num_t                       parent_2_o
);
	import cvrp_pkg::*;

	localparam int IND_W = $bits(ind_num_t);

	// Both seeds are nonzero so neither LFSR can lock up
	localparam ind_num_t LFSR_1_SEED = ind_num_t'(9'h1a5);
	localparam ind_num_t LFSR_2_SEED = ind_num_t'(9'h0c3);

	// Raw LFSR states
	ind_num_t lfsr_1_q;
	ind_num_t lfsr_2_q;

	// Feedback bits of the two polynomials
	logic lfsr_1_fb;
	logic lfsr_2_fb;

	// Proposed pair after folding into the population range
	ind_num_t prop_1;
	ind_num_t prop_2;

	// Results of the pair checks
	logic used_1;
	logic used_2;
	logic distinct;
	logic approved;
	logic hold_lfsr_1;

	////////////////////////////////////////////////////////////
	// Random pair generation
	////////////////////////////////////////////////////////////

	// First LFSR uses x^9 + x^5 + 1
	assign lfsr_1_fb = lfsr_1_q[IND_W-1] ^ lfsr_1_q[4];

	// Second LFSR uses x^9 + x^8 + x^6 + x^5 + 1 so the two sequences differ
	assign lfsr_2_fb = lfsr_2_q[IND_W-1] ^ lfsr_2_q[7] ^ lfsr_2_q[5] ^ lfsr_2_q[4];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			lfsr_1_q <= LFSR_1_SEED;
			lfsr_2_q <= LFSR_2_SEED;
		end else begin
			// Holding the first one lets the second move away from an identical pair
			if (!hold_lfsr_1) begin
				lfsr_1_q <= {lfsr_1_q[IND_W-2:0], lfsr_1_fb};
			end
			lfsr_2_q <= {lfsr_2_q[IND_W-2:0], lfsr_2_fb};
		end
	end

	// Raw values at or above the population size wrap back by one population
	assign prop_1 = (lfsr_1_q >= ind_num_t'(`CVRP_POP_SIZE)) ?
		lfsr_1_q - ind_num_t'(`CVRP_POP_SIZE) : lfsr_1_q;
	assign prop_2 = (lfsr_2_q >= ind_num_t'(`CVRP_POP_SIZE)) ?
		lfsr_2_q - ind_num_t'(`CVRP_POP_SIZE) : lfsr_2_q;

	////////////////////////////////////////////////////////////
	// Pair checks
	////////////////////////////////////////////////////////////

	// A proposal is in use when it matches either parent of any busy node
	always_comb begin
		used_1 = 1'b0;
		used_2 = 1'b0;
		for (int n = 0; n < `CVRP_NUM_NODES; n++) begin
			if (in_use_valid_i[n]) begin
				if (prop_1 == in_use_1_i[n] || prop_1 == in_use_2_i[n]) begin
					used_1 = 1'b1;
				end
				if (prop_2 == in_use_1_i[n] || prop_2 == in_use_2_i[n]) begin
					used_2 = 1'b1;
				end
			end
		end
	end

	assign distinct = (prop_1 != prop_2);
	assign approved = distinct && !used_1 && !used_2;

	// Only an identical pair with a free first member stalls the first LFSR
	assign hold_lfsr_1 = !used_1 && !distinct;

	////////////////////////////////////////////////////////////
	// Grant arbiter
	////////////////////////////////////////////////////////////

	// Later loop iterations overwrite earlier ones, so the highest requester wins
	always_comb begin
		grant_o = '0;
		if (run_enable_i && approved) begin
			for (int n = 0; n < `CVRP_NUM_NODES; n++) begin
				if (req_i[n]) begin
					grant_o = node_mask_t'(1) << n;
				end
			end
		end
	end

	// The pair is only meaningful in a cycle with a grant
	assign parent_1_o = prop_1;
	assign parent_2_o = prop_2;

endmodule

// ==== src/run_controller.sv ====
// Run phase controller; counts grants only, so results still in flight delay the final search
`include "cvrp_params.svh"

module run_controller (
	input  logic                                     clk_i,
	input  logic                                     rst_i,
	input  logic                                     grant_valid_i,
	input  cvrp_pkg::node_mask_t                     idle_i,
	input  cvrp_pkg::fitness_t [`CVRP_NUM_NODES-1:0] node_best_fitness_i,
	input  cvrp_pkg::ind_num_t [`CVRP_NUM_NODES-1:0] node_best_address_i,
	output logic                                     run_enable_o,
	output logic                                     init_phase_o,
	output logic                                     done_o,
	output cvrp_pkg::fitness_t                       best_fitness_o,
	output cvrp_pkg::ind_num_t                       best_address_o
);
	import cvrp_pkg::*;

	// Counter values seen together with the last grant of each phase
	localparam run_cnt_t LAST_INIT_RUN = run_cnt_t'(`CVRP_INIT_RUNS - 1);
	localparam run_cnt_t LAST_RUN      = run_cnt_t'(`CVRP_NUM_RUNS - 1);
	localparam node_idx_t LAST_NODE    = node_idx_t'(`CVRP_NUM_NODES - 1);

	main_state_t state_q;
	run_cnt_t    run_cnt_q;
	node_idx_t   scan_idx_q;
	logic        done_q;

	// Running winner of the final search
	fitness_t best_fit_q;
	ind_num_t best_addr_q;

	////////////////////////////////////////////////////////////
	// Main FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q     <= MS_IDLE;
			run_cnt_q   <= '0;
			scan_idx_q  <= '0;
			done_q      <= 1'b0;
			best_fit_q  <= FIT_NONE;
			best_addr_q <= IND_NONE;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				MS_IDLE: begin
					state_q <= MS_INIT_RUNS;
				end
				MS_INIT_RUNS: begin
					if (grant_valid_i) begin
						run_cnt_q <= run_cnt_q + run_cnt_t'(1);
						if (run_cnt_q == LAST_INIT_RUN) begin
							state_q <= MS_STANDARD_RUNS;
						end
					end
				end
				MS_STANDARD_RUNS: begin
					// Leaving this state drops run_enable right after the last grant
					if (grant_valid_i) begin
						run_cnt_q <= run_cnt_q + run_cnt_t'(1);
						if (run_cnt_q == LAST_RUN) begin
							state_q <= MS_WAIT_FOR_END;
						end
					end
				end
				MS_WAIT_FOR_END: begin
					if (&idle_i) begin
						state_q     <= MS_EVALUATE;
						scan_idx_q  <= '0;
						best_fit_q  <= FIT_NONE;
						best_addr_q <= IND_NONE;
					end
				end
				MS_EVALUATE: begin
					// One node per cycle in index order, strict compare favours the lower index
					if (node_best_fitness_i[scan_idx_q] < best_fit_q) begin
						best_fit_q  <= node_best_fitness_i[scan_idx_q];
						best_addr_q <= node_best_address_i[scan_idx_q];
					end
					if (scan_idx_q == LAST_NODE) begin
						state_q <= MS_FINISHED;
						done_q  <= 1'b1;
					end else begin
						scan_idx_q <= scan_idx_q + node_idx_t'(1);
					end
				end
				MS_FINISHED: begin
					state_q <= MS_FINISHED;
				end
				default: begin
					state_q <= MS_IDLE;
				end
			endcase
		end
	end

	assign run_enable_o   = (state_q == MS_INIT_RUNS) || (state_q == MS_STANDARD_RUNS);
	assign init_phase_o   = (state_q == MS_INIT_RUNS);
	assign done_o         = done_q;
	assign best_fitness_o = best_fit_q;
	assign best_address_o = best_addr_q;

endmodule

// ==== verification/cvrp_controller_props.sv ====
// Concurrent checks on grant and done outputs; bound into every cvrp_controller instance
`include "cvrp_params.svh"

module cvrp_controller_props (
	input logic               clk_i,
	input logic               rst_i,
	input logic               grant_valid_i,
	input cvrp_pkg::ind_num_t grant_parent_1_i,
	input cvrp_pkg::ind_num_t grant_parent_2_i,
	input logic               done_i
);
	timeunit 1ns;
	timeprecision 1ps;

	import cvrp_pkg::*;

	// Set from the cycle after the done pulse
	logic done_seen_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			done_seen_q <= 1'b0;
		end else if (done_i) begin
			done_seen_q <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Properties
	////////////////////////////////////////////////////////////

	// A reset cycle leaves the run controller idle, so no grant follows it
	grant_in_reset: assert property (@(posedge clk_i) rst_i |=> !grant_valid_i)
		else $error("grant_valid_o high after a reset cycle");

	grant_after_done: assert property (@(posedge clk_i) disable iff (rst_i)
		(done_i || done_seen_q) |-> !grant_valid_i)
		else $error("grant issued after done_o");

	distinct_parents: assert property (@(posedge clk_i) disable iff (rst_i)
		grant_valid_i |-> (grant_parent_1_i != grant_parent_2_i))
		else $error("grant with two equal parents");

endmodule

bind cvrp_controller cvrp_controller_props cvrp_controller_props_i (
	.clk_i            (clk_i),
	.rst_i            (rst_i),
	.grant_valid_i    (grant_valid_o),
	.grant_parent_1_i (grant_parent_1_o),
	.grant_parent_2_i (grant_parent_2_o),
	.done_i           (done_o)
);

// ==== verification/cvrp_controller_tb.sv ====
// Self-checking testbench; models the crossover engine by answering every grant 12 cycles later
`include "cvrp_params.svh"

module cvrp_controller_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import cvrp_pkg::*;

	localparam int NUM_NODES    = `CVRP_NUM_NODES;
	localparam int NUM_RUNS     = `CVRP_NUM_RUNS;
	localparam int POP_SIZE     = `CVRP_POP_SIZE;
	localparam int RESULT_DELAY = 12;
	localparam int STALL_LIMIT  = 400;
	localparam int DONE_TIMEOUT = 3000;
	localparam int AFTER_DONE   = 40;
	localparam int FIT_RANGE    = 64;
	localparam int NEVER        = 32'h7fffffff;

	logic      clk_i;
	logic      rst_i;
	logic      result_valid_i;
	node_idx_t result_node_i;
	fitness_t  result_fitness_i;
	logic      result_slot_i;
	logic      result_unchanged_i;
	logic      grant_valid_o;
	node_idx_t grant_node_o;
	ind_num_t  grant_parent_1_o;
	ind_num_t  grant_parent_2_o;
	logic      grant_init_o;
	logic      done_o;
	fitness_t  best_fitness_o;
	ind_num_t  best_address_o;

	// Record of every grant, indexed by grant number
	int       g_node [NUM_RUNS];
	ind_num_t g_p1 [NUM_RUNS];
	ind_num_t g_p2 [NUM_RUNS];
	int       due_cycle [NUM_RUNS];
	fitness_t r_fit [NUM_RUNS];
	logic     r_slot [NUM_RUNS];

	// Pair each node holds and the first cycle in which it is idle again
	ind_num_t hold_p1 [NUM_NODES];
	ind_num_t hold_p2 [NUM_NODES];
	int       release_cycle [NUM_NODES];

	int seed;
	int cycle;
	int grant_cnt;
	int sent_cnt;
	bit done_seen;

	cvrp_controller cvrp_controller_i (
		.clk_i              (clk_i),
		.rst_i              (rst_i),
		.result_valid_i     (result_valid_i),
		.result_node_i      (result_node_i),
		.result_fitness_i   (result_fitness_i),
		.result_slot_i      (result_slot_i),
		.result_unchanged_i (result_unchanged_i),
		.grant_valid_o      (grant_valid_o),
		.grant_node_o       (grant_node_o),
		.grant_parent_1_o   (grant_parent_1_o),
		.grant_parent_2_o   (grant_parent_2_o),
		.grant_init_o       (grant_init_o),
		.done_o             (done_o),
		.best_fitness_o     (best_fitness_o),
		.best_address_o     (best_address_o)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#20 clk_i = ~clk_i;
		end
	end

	////////////////////////////////////////////////////////////
	// Error handling and compare tasks
	////////////////////////////////////////////////////////////

	task automatic stop_with_failure();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_error(input string msg);
		$display("error at time %0t: %s", $time, msg);
		stop_with_failure();
	endtask

	task automatic check_fitness(input fitness_t got, input fitness_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_address(input ind_num_t got, input ind_num_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_node(input node_idx_t got, input node_idx_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	////////////////////////////////////////////////////////////
	// Grant monitor and result responder
	////////////////////////////////////////////////////////////

	task automatic record_grant();
		int n;
		int top_idle;
		n        = int'(grant_node_o);
		top_idle = -1;
		if (done_seen) report_error("a grant was issued after done_o");
		if (grant_cnt >= NUM_RUNS) report_error("more grants than runs were issued");
		if (grant_parent_1_o == grant_parent_2_o) report_error("a grant has two equal parents");
		if (int'(grant_parent_1_o) >= POP_SIZE || int'(grant_parent_2_o) >= POP_SIZE)
			report_error("a parent lies outside the population");
		if (grant_init_o !== (grant_cnt < `CVRP_INIT_RUNS))
			report_error("grant_init_o has the wrong value for this grant");
		for (int m = 0; m < NUM_NODES; m++) begin
			// A node keeps its pair until the cycle in which it is idle again
			if (cycle < release_cycle[m]) begin
				if (m == n) report_error("a node was granted again before it became idle");
				if (grant_parent_1_o == hold_p1[m] || grant_parent_1_o == hold_p2[m] ||
					grant_parent_2_o == hold_p1[m] || grant_parent_2_o == hold_p2[m])
					report_error("a parent is still held by a busy node");
			end else begin
				// Every idle node requests and the arbiter favours the highest index
				top_idle = m;
			end
		end
		if (top_idle < 0) report_error("a grant was issued while every node was busy");
		check_node(grant_node_o, node_idx_t'(top_idle), "grant_node_o");
		g_node[grant_cnt]    = n;
		g_p1[grant_cnt]      = grant_parent_1_o;
		g_p2[grant_cnt]      = grant_parent_2_o;
		due_cycle[grant_cnt] = cycle + RESULT_DELAY;
		hold_p1[n]           = grant_parent_1_o;
		hold_p2[n]           = grant_parent_2_o;
		release_cycle[n]     = NEVER;
		grant_cnt++;
	endtask

	task automatic send_result(input int k);
		int   n;
		logic unchanged;
		n         = g_node[k];
		unchanged = ((k + 1) % 3 == 0);
		r_fit[k]  = fitness_t'($unsigned($random(seed)) % FIT_RANGE);
		r_slot[k] = 1'($random(seed));
		result_valid_i     = 1'b1;
		result_node_i      = node_idx_t'(n);
		result_fitness_i   = r_fit[k];
		result_slot_i      = r_slot[k];
		result_unchanged_i = unchanged;
		// FINAL follows the result directly or after two offspring of write-back
		release_cycle[n] = cycle + (unchanged ? 2 : 2 + 2 * `CVRP_MEM_ACCESSES);
	endtask

	// Best over all results by strict less within each node and then by lowest node index
	function automatic void expected_best(output fitness_t fit, output ind_num_t addr);
		fitness_t node_fit [NUM_NODES];
		ind_num_t node_addr [NUM_NODES];
		for (int n = 0; n < NUM_NODES; n++) begin
			node_fit[n]  = '1;
			node_addr[n] = '1;
		end
		for (int k = 0; k < NUM_RUNS; k++) begin
			if (r_fit[k] < node_fit[g_node[k]]) begin
				node_fit[g_node[k]]  = r_fit[k];
				node_addr[g_node[k]] = r_slot[k] ? g_p2[k] : g_p1[k];
			end
		end
		fit  = '1;
		addr = '1;
		for (int n = 0; n < NUM_NODES; n++) begin
			if (node_fit[n] < fit) begin
				fit  = node_fit[n];
				addr = node_addr[n];
			end
		end
	endfunction

	initial begin : stimulus
		int quiet;
		rst_i              = 1'b1;
		result_valid_i     = 1'b0;
		result_node_i      = '0;
		result_fitness_i   = '0;
		result_slot_i      = 1'b0;
		result_unchanged_i = 1'b0;
		seed  = 31;
		quiet = 0;
		repeat (2) begin
			@(negedge clk_i);
			if (grant_valid_o !== 1'b0) report_error("grant_valid_o is high during reset");
		end
		rst_i = 1'b0;
		forever begin
			@(negedge clk_i);
			cycle++;
			quiet++;
			if (grant_valid_o) begin
				record_grant();
				quiet = 0;
			end
			// Grants come at most once per cycle, so due cycles never collide
			if (sent_cnt < grant_cnt && due_cycle[sent_cnt] == cycle) begin
				send_result(sent_cnt);
				sent_cnt++;
				quiet = 0;
			end else begin
				result_valid_i = 1'b0;
			end
			if (!done_seen && quiet > STALL_LIMIT) report_error("no grant or result for too long");
		end
	end

	////////////////////////////////////////////////////////////
	// Final compare
	////////////////////////////////////////////////////////////

	initial begin : compare
		int       wait_cycles;
		fitness_t exp_fit;
		ind_num_t exp_addr;
		fitness_t held_fit;
		ind_num_t held_addr;
		wait_cycles = 0;
		while (!done_seen) begin
			@(negedge clk_i);
			if (!rst_i && done_o) begin
				done_seen = 1'b1;
			end else begin
				wait_cycles++;
				if (wait_cycles > DONE_TIMEOUT) report_error("timeout while waiting for done_o");
			end
		end
		if (grant_cnt != NUM_RUNS) report_error("done_o came with the wrong number of grants");
		if (sent_cnt != NUM_RUNS) report_error("done_o came before the last result was sent");
		expected_best(exp_fit, exp_addr);
		check_fitness(best_fitness_o, exp_fit, "best_fitness_o");
		check_address(best_address_o, exp_addr, "best_address_o");
		held_fit  = best_fitness_o;
		held_addr = best_address_o;
		// The winner must stay put and done_o must not pulse again
		repeat (AFTER_DONE) begin
			@(negedge clk_i);
			if (done_o) report_error("done_o pulsed more than once");
			check_fitness(best_fitness_o, held_fit, "best_fitness_o after done_o");
			check_address(best_address_o, held_addr, "best_address_o after done_o");
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule
